//--- group_norm_pkg.sv
// Group normalization shared definitions
// Dimensions, arithmetic widths, stream payload and statistics types

`default_nettype none

package group_norm_pkg;

    // Spatial and tiling dimensions
    localparam int TOTAL_DIM0     = 4;
    localparam int TOTAL_DIM1     = 4;
    localparam int COMPUTE_DIM0   = 2;
    localparam int COMPUTE_DIM1   = 2;
    localparam int LANES          = COMPUTE_DIM0 * COMPUTE_DIM1;
    localparam int GROUP_CHANNELS = 2;

    // Group size must stay a power of two so the mean is a shift
    localparam int GROUP_ELEMS    = TOTAL_DIM0 * TOTAL_DIM1 * GROUP_CHANNELS;
    localparam int GROUP_SHIFT    = $clog2(GROUP_ELEMS);
    localparam int GROUP_BEATS    = GROUP_ELEMS / LANES;
    localparam int BEAT_CNT_WIDTH = $clog2(GROUP_BEATS);

    // Arithmetic widths
    localparam int WIDTH          = 8;
    localparam int FRAC_WIDTH     = 4;
    localparam int RECIP_FRAC     = 8;
    localparam int SUM_WIDTH      = WIDTH + GROUP_SHIFT + 1;
    localparam int SQ_WIDTH       = 2 * WIDTH + GROUP_SHIFT;
    localparam int VAR_WIDTH      = 2 * WIDTH;
    localparam int INV_WIDTH      = RECIP_FRAC + 1;
    localparam int STEP_WIDTH     = $clog2(INV_WIDTH);
    localparam int SUM_PART_WIDTH = WIDTH + $clog2(LANES);
    localparam int SQ_PART_WIDTH  = 2 * WIDTH + $clog2(LANES);
    localparam int PROD_WIDTH     = WIDTH + INV_WIDTH + 2;
    localparam int FIFO_DEPTH     = 2 * GROUP_BEATS;

    // Constants shared with the reference model
    localparam int OUT_SHIFT      = RECIP_FRAC - FRAC_WIDTH;
    localparam int RECIP_ONE      = 1 << RECIP_FRAC;
    localparam int SAT_MAX        = (1 << (WIDTH - 1)) - 1;
    localparam int SAT_MIN        = -(1 << (WIDTH - 1));

    typedef logic signed [WIDTH-1:0] elem_t;

    typedef struct packed {
        elem_t [LANES-1:0] lane;
    } tile_t;

    typedef struct packed {
        elem_t                mean;
        logic [INV_WIDTH-1:0] inv_std;
    } norm_params_t;

    typedef struct packed {
        elem_t                mean;
        logic [VAR_WIDTH-1:0] variance;
    } stats_t;

endpackage

`default_nettype wire

//--- fixed_adder_tree.sv
// Pipelined signed adder tree
// Two registered levels reduce one beat of lanes to a single sum;
// the whole pipe stalls when its output is held

`timescale 1ns/100ps
`default_nettype none

module fixed_adder_tree #(
    parameter int IN_SIZE  = 4,
    parameter int IN_WIDTH = 8
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic signed [IN_WIDTH-1:0]                 data_in [IN_SIZE],
    input  logic                                       in_valid,
    output logic                                       in_ready,
    output logic signed [IN_WIDTH+$clog2(IN_SIZE)-1:0] data_out,
    output logic                                       out_valid,
    input  logic                                       out_ready
);

    // First level holds pairwise sums, IN_SIZE is expected to be even
    logic signed [IN_WIDTH:0]                 pair_q [IN_SIZE/2];
    logic                                     pair_valid;
    logic signed [IN_WIDTH+$clog2(IN_SIZE)-1:0] total;
    logic                                     advance;

    assign advance  = !out_valid || out_ready;
    assign in_ready = advance;

    always_comb begin
        total = '0;
        for (int i = 0; i < IN_SIZE / 2; i++) begin
            total = total + pair_q[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pair_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else if (advance) begin
            pair_valid <= in_valid;
            out_valid  <= pair_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            for (int i = 0; i < IN_SIZE / 2; i++) begin
                pair_q[i] <= data_in[2*i] + data_in[2*i+1];
            end
            data_out <= total;
        end
    end

    // Held result must not change until taken
    hold_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(data_out));

endmodule

`default_nettype wire

//--- tile_fifo.sv
// Synchronous FIFO for buffered beats
// Circular buffer with occupancy count and zero-latency read

`timescale 1ns/100ps
`default_nettype none

module tile_fifo #(
    parameter int  DEPTH     = 16,
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t wr_data,
    input  logic     wr_valid,
    output logic     wr_ready,
    output payload_t rd_data,
    output logic     rd_valid,
    input  logic     rd_ready
);

    payload_t                   mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr, rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_wr, do_rd;

    assign wr_ready = (count != DEPTH);
    assign rd_valid = (count != 0);
    assign rd_data  = mem[rd_ptr];
    assign do_wr    = wr_valid && wr_ready;
    assign do_rd    = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= DEPTH);

endmodule

`default_nettype wire

//--- group_stats.sv
// Group statistics
// Sums the lanes and their squares over one group and produces
// the floor mean and the clamped variance

`timescale 1ns/100ps
`default_nettype none

module group_stats
    import group_norm_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  tile_t  tile,
    input  logic   tile_valid,
    output logic   tile_ready,
    output stats_t stats,
    output logic   stats_valid,
    input  logic   stats_ready
);

    logic signed [WIDTH-1:0]          lanes   [LANES];
    logic signed [2*WIDTH-1:0]        squares [LANES];
    logic signed [SUM_PART_WIDTH-1:0] sum_part;
    logic signed [SQ_PART_WIDTH-1:0]  sq_part;
    logic                             sum_in_ready, sq_in_ready;
    logic                             sum_valid, sq_valid;
    logic                             tree_valid, result_free, take, last;
    logic [BEAT_CNT_WIDTH-1:0]        beat_cnt;
    logic signed [SUM_WIDTH-1:0]      acc_sum, sum_total, mean_full;
    logic signed [SQ_WIDTH-1:0]       acc_sq, sq_total;
    logic [VAR_WIDTH-1:0]             ex2, mean_sq;
    stats_t                           result;

    assign tile_ready  = sum_in_ready && sq_in_ready && !stats_valid;
    assign tree_valid  = tile_valid && tile_ready;
    assign result_free = !stats_valid || stats_ready;
    assign take        = sum_valid && sq_valid && result_free;
    assign last        = (beat_cnt == BEAT_CNT_WIDTH'(GROUP_BEATS - 1));

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lanes[i]   = tile.lane[i];
            squares[i] = tile.lane[i] * tile.lane[i];
        end
    end

    fixed_adder_tree #(.IN_SIZE(LANES), .IN_WIDTH(WIDTH)) sum_tree (
        .clk(clk), .rst(rst),
        .data_in(lanes), .in_valid(tree_valid), .in_ready(sum_in_ready),
        .data_out(sum_part), .out_valid(sum_valid), .out_ready(result_free)
    );

    fixed_adder_tree #(.IN_SIZE(LANES), .IN_WIDTH(2 * WIDTH)) square_tree (
        .clk(clk), .rst(rst),
        .data_in(squares), .in_valid(tree_valid), .in_ready(sq_in_ready),
        .data_out(sq_part), .out_valid(sq_valid), .out_ready(result_free)
    );

    // Final statistics from the running totals
    always_comb begin
        sum_total      = acc_sum + sum_part;
        sq_total       = acc_sq + sq_part;
        mean_full      = sum_total >>> GROUP_SHIFT;
        result.mean    = mean_full[WIDTH-1:0];
        mean_sq        = result.mean * result.mean;
        ex2            = sq_total[SQ_WIDTH-1:GROUP_SHIFT];
        // Floor of the mean can push mean squared above E[x^2]
        result.variance = (ex2 > mean_sq) ? ex2 - mean_sq : '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt    <= '0;
            acc_sum     <= '0;
            acc_sq      <= '0;
            stats_valid <= 1'b0;
        end else begin
            if (stats_valid && stats_ready) begin
                stats_valid <= 1'b0;
            end
            if (take && last) begin
                beat_cnt    <= '0;
                acc_sum     <= '0;
                acc_sq      <= '0;
                stats_valid <= 1'b1;
            end else if (take) begin
                beat_cnt <= beat_cnt + 1'b1;
                acc_sum  <= sum_total;
                acc_sq   <= sq_total;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && last) begin
            stats <= result;
        end
    end

    // Both partial sums must belong to the same beat
    trees_in_step: assert property (@(posedge clk) disable iff (rst)
        sum_valid == sq_valid);

endmodule

`default_nettype wire

//--- inv_std_unit.sv
// Reciprocal standard deviation
// Bit-serial square root of the variance, then a restoring division
// of 2^RECIP_FRAC by the root; the mean rides along

`timescale 1ns/100ps
`default_nettype none

module inv_std_unit
    import group_norm_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  stats_t       stats,
    input  logic         stats_valid,
    output logic         stats_ready,
    output norm_params_t params,
    output logic         params_valid,
    input  logic         params_ready
);

    typedef enum logic [1:0] {S_IDLE, S_ROOT, S_DIVIDE, S_DONE} state_t;

    state_t                state;
    logic [STEP_WIDTH-1:0] step;
    logic [VAR_WIDTH-1:0]  rad;
    logic [WIDTH:0]        rem;
    logic [WIDTH-1:0]      root, root_next;
    logic [INV_WIDTH-1:0]  quot;
    elem_t                 mean;
    logic [WIDTH+2:0]      sq_rem, sq_trial, sq_diff;
    logic                  sq_fit, div_fit;
    logic [WIDTH:0]        div_rem;

    assign stats_ready    = (state == S_IDLE);
    assign params_valid   = (state == S_DONE);
    assign params.mean    = mean;
    assign params.inv_std = quot;

    always_comb begin
        // Two radicand bits per root bit
        sq_rem    = {rem, rad[VAR_WIDTH-1 -: 2]};
        sq_trial  = {1'b0, root, 2'b01};
        sq_diff   = sq_rem - sq_trial;
        sq_fit    = (sq_rem >= sq_trial);
        root_next = {root[WIDTH-2:0], sq_fit};
        // Dividend bits shift out of the top of quot
        div_rem   = {rem[WIDTH-1:0], quot[INV_WIDTH-1]};
        div_fit   = (div_rem >= {1'b0, root});
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            step  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (stats_valid) begin
                        rad   <= stats.variance;
                        mean  <= stats.mean;
                        rem   <= '0;
                        root  <= '0;
                        step  <= '0;
                        state <= S_ROOT;
                    end
                end
                S_ROOT: begin
                    rad <= rad << 2;
                    rem <= sq_fit ? sq_diff[WIDTH:0] : sq_rem[WIDTH:0];
                    if (step == STEP_WIDTH'(WIDTH - 1)) begin
                        // Zero variance divides by one
                        root  <= (root_next == '0) ? WIDTH'(1) : root_next;
                        rem   <= '0;
                        quot  <= INV_WIDTH'(RECIP_ONE);
                        step  <= '0;
                        state <= S_DIVIDE;
                    end else begin
                        root <= root_next;
                        step <= step + 1'b1;
                    end
                end
                S_DIVIDE: begin
                    quot <= {quot[INV_WIDTH-2:0], div_fit};
                    rem  <= div_fit ? div_rem - {1'b0, root} : div_rem;
                    if (step == STEP_WIDTH'(INV_WIDTH - 1)) begin
                        state <= S_DONE;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                default: begin
                    if (params_ready) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    divisor_nonzero: assert property (@(posedge clk) disable iff (rst)
        state == S_DIVIDE |-> root != '0);

endmodule

`default_nettype wire

//--- norm_scale.sv
// Normalization output stage
// Applies (x - mean) * inv_std per lane with floor shift and
// signed 8-bit saturation, one parameter set per group

`timescale 1ns/100ps
`default_nettype none

module norm_scale
    import group_norm_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  norm_params_t params,
    input  logic         params_valid,
    output logic         params_ready,
    input  tile_t        tile,
    input  logic         tile_valid,
    output logic         tile_ready,
    output tile_t        out_tile,
    output logic         out_valid,
    input  logic         out_ready
);

    norm_params_t              cur;
    logic                      loaded;
    logic [BEAT_CNT_WIDTH-1:0] beat_cnt;
    logic                      pop;
    tile_t                     scaled;

    function automatic elem_t scale_lane(elem_t x, norm_params_t p);
        logic signed [WIDTH:0]      diff;
        logic signed [PROD_WIDTH-1:0] prod;
        diff = x - p.mean;
        prod = diff * $signed({1'b0, p.inv_std});
        prod = prod >>> OUT_SHIFT;
        if (prod > SAT_MAX) begin
            return elem_t'(SAT_MAX);
        end else if (prod < SAT_MIN) begin
            return elem_t'(SAT_MIN);
        end
        return prod[WIDTH-1:0];
    endfunction

    assign params_ready = !loaded;
    // No pops until a parameter set is held
    assign tile_ready   = loaded && (!out_valid || out_ready);
    assign pop          = tile_valid && tile_ready;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            scaled.lane[i] = scale_lane(tile.lane[i], cur);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            loaded    <= 1'b0;
            beat_cnt  <= '0;
            out_valid <= 1'b0;
        end else begin
            if (params_valid && params_ready) begin
                loaded <= 1'b1;
            end
            if (pop) begin
                out_valid <= 1'b1;
                if (beat_cnt == BEAT_CNT_WIDTH'(GROUP_BEATS - 1)) begin
                    beat_cnt <= '0;
                    loaded   <= 1'b0;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (params_valid && params_ready) begin
            cur <= params;
        end
        if (pop) begin
            out_tile <= scaled;
        end
    end

endmodule

`default_nettype wire

//--- group_norm_2d.sv
// Streaming group normalization, top level
// Each accepted beat is buffered and summarized at once; the buffer
// is replayed through the scaling stage once statistics are ready

`timescale 1ns/100ps
`default_nettype none

module group_norm_2d
    import group_norm_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  tile_t in_tile,
    input  logic  in_valid,
    output logic  in_ready,
    output tile_t out_tile,
    output logic  out_valid,
    input  logic  out_ready
);

    logic         fifo_wr_ready, fifo_rd_valid, fifo_rd_ready;
    tile_t        fifo_rd_data;
    logic         stats_tile_ready;
    stats_t       stats;
    logic         stats_valid, stats_ready;
    norm_params_t params;
    logic         params_valid, params_ready;

    // Beat is taken only when both sides can take it
    assign in_ready = fifo_wr_ready && stats_tile_ready;

    tile_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(tile_t)) beat_fifo (
        .clk(clk), .rst(rst),
        .wr_data(in_tile), .wr_valid(in_valid && stats_tile_ready),
        .wr_ready(fifo_wr_ready),
        .rd_data(fifo_rd_data), .rd_valid(fifo_rd_valid), .rd_ready(fifo_rd_ready)
    );

    group_stats stats_unit (
        .clk(clk), .rst(rst),
        .tile(in_tile), .tile_valid(in_valid && fifo_wr_ready),
        .tile_ready(stats_tile_ready),
        .stats(stats), .stats_valid(stats_valid), .stats_ready(stats_ready)
    );

    inv_std_unit recip_unit (
        .clk(clk), .rst(rst),
        .stats(stats), .stats_valid(stats_valid), .stats_ready(stats_ready),
        .params(params), .params_valid(params_valid), .params_ready(params_ready)
    );

    norm_scale scale_unit (
        .clk(clk), .rst(rst),
        .params(params), .params_valid(params_valid), .params_ready(params_ready),
        .tile(fifo_rd_data), .tile_valid(fifo_rd_valid), .tile_ready(fifo_rd_ready),
        .out_tile(out_tile), .out_valid(out_valid), .out_ready(out_ready)
    );

endmodule

`default_nettype wire

//--- tb_group_norm_2d.sv
// Testbench for the streaming group normalization block
// Directed tests checked against a reference model of the group arithmetic

`timescale 1ns/100ps
`default_nettype none

module tb_group_norm_2d
    import group_norm_pkg::*;
();

    localparam logic [31:0] SEED = 32'h55fb24cc;
    // Fourteen groups at under 150 cycles each even with back-pressure
    localparam int CYCLE_LIMIT = 4000;

    logic        clk;
    logic        rst;
    tile_t       in_tile;
    logic        in_valid;
    logic        in_ready;
    tile_t       out_tile;
    logic        out_valid;
    logic        out_ready;

    logic [31:0] data_state;
    logic [31:0] stall_state;
    logic        stall_out;
    logic        stall_now;
    logic        stall_seen;
    int          cycles;
    int          grp [GROUP_ELEMS];
    int          expected_q [$];

    group_norm_2d UUT (
        .clk(clk), .rst(rst),
        .in_tile(in_tile), .in_valid(in_valid), .in_ready(in_ready),
        .out_tile(out_tile), .out_valid(out_valid), .out_ready(out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_elem();
        elem_t e;
        data_state = xorshift32(data_state);
        e = data_state[7:0];
        return e;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            abort_run($sformatf("FAILED at %0t: %s expected %0d, actual %0d",
                $time, name, expected, actual));
        end
    endtask

    // Floor mean, clamped variance, integer root and floor reciprocal
    task automatic push_expected();
        int sum, sumsq;
        int mean, variance;
        int root, inv, v;
        sum   = 0;
        sumsq = 0;
        for (int i = 0; i < GROUP_ELEMS; i++) begin
            sum   += grp[i];
            sumsq += grp[i] * grp[i];
        end
        mean     = sum >>> GROUP_SHIFT;
        variance = (sumsq >>> GROUP_SHIFT) - mean * mean;
        if (variance < 0) begin
            variance = 0;
        end
        root = 0;
        while ((root + 1) * (root + 1) <= variance) begin
            root++;
        end
        if (root == 0) begin
            root = 1;
        end
        inv = RECIP_ONE / root;
        for (int i = 0; i < GROUP_ELEMS; i++) begin
            v = ((grp[i] - mean) * inv) >>> OUT_SHIFT;
            if (v > SAT_MAX) begin
                v = SAT_MAX;
            end else if (v < SAT_MIN) begin
                v = SAT_MIN;
            end
            expected_q.push_back(v);
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("out_valid", 0, out_valid);
        check_value("in_ready", 1, in_ready);
    endtask

    // Holds the beat until in_ready is seen at a rising edge
    task automatic send_beat(input int beat);
        logic taken;
        for (int l = 0; l < LANES; l++) begin
            in_tile.lane[l] = elem_t'(grp[beat * LANES + l]);
        end
        in_valid = 1'b1;
        taken    = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = in_ready;
            if (!taken) begin
                stall_seen = 1'b1;
            end
            #1;
        end
    endtask

    task automatic send_group(input bit gaps, input int beats);
        for (int b = 0; b < beats; b++) begin
            send_beat(b);
            if (gaps && (rand_elem() & 3) == 0) begin
                in_valid = 1'b0;
                repeat (1 + (rand_elem() & 1)) @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic wait_drain();
        while (expected_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        // A few idle cycles so a stray beat still reaches the monitor
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic fill_random();
        for (int i = 0; i < GROUP_ELEMS; i++) begin
            grp[i] = rand_elem();
        end
    endtask

    task automatic run_group(input bit gaps);
        push_expected();
        send_group(gaps, GROUP_BEATS);
        in_valid = 1'b0;
        wait_drain();
    endtask

    task automatic test_constant();
        for (int i = 0; i < GROUP_ELEMS; i++) begin
            grp[i] = 37;
        end
        run_group(1'b0);
    endtask

    task automatic test_ramp();
        // Mean -1, variance 84, root 9, reciprocal 28
        for (int i = 0; i < GROUP_ELEMS; i++) begin
            grp[i] = i - 16;
        end
        run_group(1'b0);
    endtask

    task automatic test_extreme();
        for (int i = 0; i < GROUP_ELEMS; i++) begin
            grp[i] = (i % 2 == 0) ? SAT_MIN : SAT_MAX;
        end
        run_group(1'b0);
        // Tiny variance of a flat group pushes one outlier past each limit
        for (int i = 0; i < GROUP_ELEMS; i++) begin
            grp[i] = 0;
        end
        grp[13] = 10;
        run_group(1'b0);
        grp[13] = -10;
        run_group(1'b0);
    endtask

    task automatic test_back_to_back();
        for (int g = 0; g < 4; g++) begin
            fill_random();
            push_expected();
            send_group(1'b0, GROUP_BEATS);
        end
        in_valid = 1'b0;
        wait_drain();
    endtask

    task automatic test_back_pressure();
        stall_seen = 1'b0;
        stall_out  = 1'b1;
        for (int g = 0; g < 3; g++) begin
            fill_random();
            push_expected();
            send_group(1'b1, GROUP_BEATS);
        end
        in_valid = 1'b0;
        wait_drain();
        stall_out = 1'b0;
        check_value("in_ready_low_seen", 1, stall_seen);
    endtask

    task automatic test_reset();
        // Partial group is dropped by the reset
        fill_random();
        send_group(1'b0, 5);
        in_valid = 1'b0;
        apply_reset();
        fill_random();
        run_group(1'b0);
    endtask

    // Output ready pattern follows the mode latched at the edge
    always @(posedge clk) begin
        stall_now = stall_out;
        #1;
        if (stall_now) begin
            stall_state = xorshift32(stall_state);
            out_ready   = stall_state[0] & stall_state[1];
        end else begin
            out_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (expected_q.size() < LANES) begin
                abort_run($sformatf("Output beat with no expected data at %0t", $time));
            end else begin
                for (int l = 0; l < LANES; l++) begin
                    check_value($sformatf("out_tile.lane[%0d]", l),
                        expected_q.pop_front(), out_tile.lane[l]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            abort_run($sformatf("Timeout after %0d cycles, run did not finish", CYCLE_LIMIT));
        end
    end

    initial begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_tile     = '0;
        out_ready   = 1'b1;
        stall_out   = 1'b0;
        stall_seen  = 1'b0;
        cycles      = 0;
        data_state  = SEED;
        stall_state = xorshift32(SEED);
        apply_reset();
        test_constant();
        test_ramp();
        test_extreme();
        test_back_to_back();
        test_back_pressure();
        test_reset();
        if (expected_q.size() != 0) begin
            abort_run($sformatf("%0d expected values never left the DUT", expected_q.size()));
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- group_norm.f
group_norm_pkg.sv
fixed_adder_tree.sv
tile_fifo.sv
group_stats.sv
inv_std_unit.sv
norm_scale.sv
group_norm_2d.sv
tb_group_norm_2d.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the group normalization testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_group_norm_2d -f group_norm.f -o tb_group_norm_2d
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_group_norm_2d
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation ended with status $sim_status"
    exit $sim_status
fi

echo "Simulation ended normally"
exit 0
